/* hw/segdisp_defs.svh */
`ifndef SEGDISP_DEFS_SVH
`define SEGDISP_DEFS_SVH

// Number of display bytes, two hex digits each
`define SLOT_COUNT 4

// sys_clk cycles per half period of segled_clk
`define SCLK_DIV 4

// Command classes in the upper nibble of a command byte
`define CMD_WRITE 4'h1
`define CMD_BLANK 4'h2

// Lower nibble of a command byte is the slot index
`define CMD_IDX_W 4

`endif

/* hw/segdisp_pkg.sv */
`default_nettype none

package segdisp_pkg;

  typedef logic [7:0] host_byte_t;   // One byte of the host stream
  typedef logic [1:0] slot_idx_t;    // Display slot number

  // Active low, bit 0 = a ... bit 6 = g, bit 7 = dp
  typedef logic [7:0] seg_code_t;

  typedef struct packed {
    seg_code_t hi;                   // Glyph of upper nibble
    seg_code_t lo;                   // Glyph of lower nibble
  } slot_seg_t;

  typedef struct packed {
    logic       wr;                  // Write data byte into slot idx
    logic       blank_wr;            // Load blank flag from data bit 0
    slot_idx_t  idx;
    host_byte_t data;
  } slot_wr_t;

  typedef enum logic {
    DEC_CMD,
    DEC_DATA
  } dec_state_t;

  typedef enum logic [1:0] {
    SCAN_LOAD,
    SCAN_SHIFT,
    SCAN_STROBE
  } scan_state_t;

endpackage

`default_nettype wire

/* hw/cmd_decoder.sv */
`timescale 1ns/100ps
`default_nettype none
`include "segdisp_defs.svh"

module cmd_decoder (
  input  wire                     sys_clk,
  input  wire                     sys_rst_n,
  input  wire segdisp_pkg::host_byte_t host_data,
  input  wire                     host_stb,
  output segdisp_pkg::slot_wr_t   slot_wr,
  output logic                    cmd_error
);

  segdisp_pkg::dec_state_t state;
  segdisp_pkg::host_byte_t cmd_q;
  logic                    idx_ok;
  logic                    is_write;
  logic                    is_blank;

  // Legality of the pending command
  assign idx_ok   = (cmd_q[`CMD_IDX_W-1:0] < `SLOT_COUNT);
  assign is_write = (cmd_q[7:4] == `CMD_WRITE) && idx_ok;
  assign is_blank = (cmd_q[7:4] == `CMD_BLANK) && idx_ok;

  always_ff @(posedge sys_clk) begin
    if (host_stb && state == segdisp_pkg::DEC_CMD) begin
      cmd_q <= host_data;              // Held until its data byte
    end
  end

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      state     <= segdisp_pkg::DEC_CMD;
      slot_wr   <= '0;
      cmd_error <= 1'b0;
    end else begin
      slot_wr.wr       <= 1'b0;        // Strobes last one cycle
      slot_wr.blank_wr <= 1'b0;
      if (host_stb) begin
        case (state)
          segdisp_pkg::DEC_CMD: begin
            state <= segdisp_pkg::DEC_DATA;
          end
          default: begin
            // Data byte is consumed even for an illegal command
            state            <= segdisp_pkg::DEC_CMD;
            slot_wr.wr       <= is_write;
            slot_wr.blank_wr <= is_blank;
            slot_wr.idx      <= segdisp_pkg::slot_idx_t'(cmd_q[`CMD_IDX_W-1:0]);
            slot_wr.data     <= host_data;
            if (!is_write && !is_blank) begin
              cmd_error <= 1'b1;       // Sticky until reset
            end
          end
        endcase
      end
    end
  end

  a_one_strobe: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
    !(slot_wr.wr && slot_wr.blank_wr))
    else $error("cmd_decoder: write and blank strobes high together");

endmodule

`default_nettype wire

/* hw/digit_slot.sv */
`timescale 1ns/100ps
`default_nettype none

module digit_slot #(
  parameter int SLOT_ID = 0
) (
  input  wire                        sys_clk,
  input  wire                        sys_rst_n,
  input  wire segdisp_pkg::slot_wr_t slot_wr,
  output segdisp_pkg::slot_seg_t     seg
);

  segdisp_pkg::host_byte_t byte_q;
  logic                    blank_q;
  logic                    hit;

  // Hex digit to active-low segment pattern, dp off
  function automatic segdisp_pkg::seg_code_t glyph(input logic [3:0] nib);
    case (nib)
      4'h0: glyph = 8'hC0;
      4'h1: glyph = 8'hF9;
      4'h2: glyph = 8'hA4;
      4'h3: glyph = 8'hB0;
      4'h4: glyph = 8'h99;
      4'h5: glyph = 8'h92;
      4'h6: glyph = 8'h82;
      4'h7: glyph = 8'hF8;
      4'h8: glyph = 8'h80;
      4'h9: glyph = 8'h90;
      4'hA: glyph = 8'h88;
      4'hB: glyph = 8'h83;
      4'hC: glyph = 8'hC6;
      4'hD: glyph = 8'hA1;
      4'hE: glyph = 8'h86;
      default: glyph = 8'h8E;
    endcase
  endfunction

  assign hit = (slot_wr.idx == segdisp_pkg::slot_idx_t'(SLOT_ID));

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      byte_q  <= '0;
      blank_q <= 1'b0;
    end else begin
      if (slot_wr.wr && hit) byte_q <= slot_wr.data;
      if (slot_wr.blank_wr && hit) blank_q <= slot_wr.data[0];
    end
  end

  // Segment codes follow the stored byte one cycle later
  always_ff @(posedge sys_clk) begin
    if (blank_q) begin
      seg <= '1;                       // All segments dark
    end else begin
      seg.hi <= glyph(byte_q[7:4]);
      seg.lo <= glyph(byte_q[3:0]);
    end
  end

  // Blank strobe reaches seg through blank_q
  a_blank_dark: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
    slot_wr.blank_wr && hit && slot_wr.data[0] |-> ##2 (seg == '1))
    else $error("digit_slot %0d: blanked slot shows segments", SLOT_ID);

endmodule

`default_nettype wire

/* hw/hc595_scanner.sv */
`timescale 1ns/100ps
`default_nettype none
`include "segdisp_defs.svh"

module hc595_scanner (
  input  wire                         sys_clk,
  input  wire                         sys_rst_n,
  input  wire segdisp_pkg::slot_seg_t slots [`SLOT_COUNT],
  output logic                        segled_clk,
  output logic                        segled_dat,
  output logic                        segled_str
);

  localparam int DIGITS = 2 * `SLOT_COUNT;
  localparam int DIV_W  = $clog2(`SCLK_DIV);
  localparam int DIG_W  = $clog2(DIGITS);

  segdisp_pkg::scan_state_t state;
  logic [DIV_W-1:0]         div_cnt;
  logic [3:0]               bit_cnt;
  logic [DIG_W-1:0]         digit_cnt;
  logic [14:0]              frame_q;
  logic [15:0]              frame_new;
  segdisp_pkg::slot_idx_t   slot_sel;
  segdisp_pkg::seg_code_t   digit_seg;
  logic [7:0]               digit_sel;
  logic                     half_end;
  logic                     bit_end;

  // Even digit shows the upper nibble of its slot
  assign slot_sel  = segdisp_pkg::slot_idx_t'(digit_cnt >> 1);
  assign digit_seg = digit_cnt[0] ? slots[slot_sel].lo : slots[slot_sel].hi;
  assign digit_sel = 8'd1 << digit_cnt;             // One-hot select
  assign frame_new = {digit_seg, digit_sel};

  assign half_end = (div_cnt == DIV_W'(`SCLK_DIV - 1));
  assign bit_end  = (state == segdisp_pkg::SCAN_SHIFT) && half_end && segled_clk;

  always_ff @(posedge sys_clk) begin
    if (state == segdisp_pkg::SCAN_LOAD) begin
      frame_q <= frame_new[14:0];                   // Bit 15 goes straight to segled_dat
    end else if (bit_end) begin
      frame_q <= {frame_q[13:0], 1'b0};             // MSB goes out first
    end
  end

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      state      <= segdisp_pkg::SCAN_LOAD;
      div_cnt    <= '0;
      bit_cnt    <= '0;
      digit_cnt  <= '0;
      segled_clk <= 1'b0;
      segled_dat <= 1'b0;
      segled_str <= 1'b0;
    end else begin
      segled_str <= 1'b0;
      case (state)
        segdisp_pkg::SCAN_LOAD: begin
          segled_dat <= frame_new[15];              // First bit while clock low
          div_cnt    <= '0;
          bit_cnt    <= '0;
          state      <= segdisp_pkg::SCAN_SHIFT;
        end
        segdisp_pkg::SCAN_SHIFT: begin
          div_cnt <= half_end ? '0 : div_cnt + 1'b1;
          if (half_end) segled_clk <= ~segled_clk;
          if (bit_end) begin
            // Falling edge, next bit set up during the low half
            segled_dat <= frame_q[14];
            bit_cnt    <= bit_cnt + 1'b1;
            if (bit_cnt == 4'd15) begin
              segled_str <= 1'b1;                   // Latch the full frame
              state      <= segdisp_pkg::SCAN_STROBE;
            end
          end
        end
        segdisp_pkg::SCAN_STROBE: begin
          digit_cnt <= (digit_cnt == DIG_W'(DIGITS - 1)) ? '0 : digit_cnt + 1'b1;
          state     <= segdisp_pkg::SCAN_LOAD;
        end
        default: state <= segdisp_pkg::SCAN_LOAD;
      endcase
    end
  end

  a_str_clk_low: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
    !(segled_str && segled_clk))
    else $error("hc595_scanner: latch strobe while serial clock high");

endmodule

`default_nettype wire

/* hw/fx2_link_status.sv */
`timescale 1ns/100ps
`default_nettype none

module fx2_link_status (
  input  wire  sys_clk,
  input  wire  sys_rst_n,
  input  wire  flag_a,
  input  wire  flag_b,
  input  wire  flag_c,
  input  wire  flag_d,
  output logic buff_ok,
  output logic ifclk
);

  logic [3:0] flag_meta;
  logic [3:0] flag_sync;

  // Flags come from the FX2 domain
  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      flag_meta <= '0;
      flag_sync <= '0;
    end else begin
      flag_meta <= {flag_d, flag_c, flag_b, flag_a};
      flag_sync <= flag_meta;
    end
  end

  // A empty-low, B high, C low, D high means buffers are fine
  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      buff_ok <= 1'b0;
    end else begin
      buff_ok <= (flag_sync == 4'b1010);
    end
  end

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      ifclk <= 1'b0;
    end else begin
      ifclk <= ~ifclk;                 // sys_clk / 2
    end
  end

endmodule

`default_nettype wire

/* hw/segdisp_top.sv */
`timescale 1ns/100ps
`default_nettype none
`include "segdisp_defs.svh"

module segdisp_top (
  input  wire                          sys_clk,
  input  wire                          sys_rst_n,
  input  wire segdisp_pkg::host_byte_t host_data,
  input  wire                          host_stb,
  input  wire                          flag_a,
  input  wire                          flag_b,
  input  wire                          flag_c,
  input  wire                          flag_d,
  output wire                          led,
  output wire                          cy_ifclk,
  output wire                          segled_clk,
  output wire                          segled_dat,
  output wire                          segled_str,
  output wire                          cmd_error
);

  wire segdisp_pkg::slot_wr_t  slot_wr;
  wire segdisp_pkg::slot_seg_t slot_segs [`SLOT_COUNT];

  cmd_decoder u_decoder (
    .sys_clk   (sys_clk),
    .sys_rst_n (sys_rst_n),
    .host_data (host_data),
    .host_stb  (host_stb),
    .slot_wr   (slot_wr),
    .cmd_error (cmd_error)
  );

  // One slot per display byte
  for (genvar k = 0; k < `SLOT_COUNT; k++) begin : g_slot
    digit_slot #(.SLOT_ID(k)) u_slot (
      .sys_clk   (sys_clk),
      .sys_rst_n (sys_rst_n),
      .slot_wr   (slot_wr),
      .seg       (slot_segs[k])
    );
  end

  hc595_scanner u_scanner (
    .sys_clk    (sys_clk),
    .sys_rst_n  (sys_rst_n),
    .slots      (slot_segs),
    .segled_clk (segled_clk),
    .segled_dat (segled_dat),
    .segled_str (segled_str)
  );

  fx2_link_status u_link (
    .sys_clk   (sys_clk),
    .sys_rst_n (sys_rst_n),
    .flag_a    (flag_a),
    .flag_b    (flag_b),
    .flag_c    (flag_c),
    .flag_d    (flag_d),
    .buff_ok   (led),                  // LED lit while buffers ok
    .ifclk     (cy_ifclk)
  );

endmodule

`default_nettype wire

/* sim/tb_clock.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
  parameter real PERIOD_NS = 8.0
) (
  output logic sys_clk
);

  initial sys_clk = 1'b0;
  always #(PERIOD_NS / 2.0) sys_clk = ~sys_clk;   // Free running

endmodule

`default_nettype wire

/* sim/segdisp_tb.sv */
`timescale 1ns/100ps
`default_nettype none
`include "segdisp_defs.svh"

module segdisp_tb;

  localparam int FRAME_CYCLES = 16 * 2 * `SCLK_DIV + 2;
  localparam int SCAN_CYCLES  = 2 * `SLOT_COUNT * FRAME_CYCLES;
  localparam int NUM_TESTS    = 5;
  localparam int RESET_CYCLES = 8;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_TESTS * 6 * SCAN_CYCLES;

  wire  sys_clk;
  logic sys_rst_n;
  segdisp_pkg::host_byte_t host_data;
  logic host_stb;
  logic flag_a, flag_b, flag_c, flag_d;
  wire  led, cy_ifclk, segled_clk, segled_dat, segled_str, cmd_error;

  logic [31:0] sb_bytes;                // Written bytes, slot k at [8k+7:8k]
  logic [3:0]  sb_blank;
  logic [31:0] frame_bytes;             // Scoreboard as it was when the frame loaded
  logic [3:0]  frame_blank;
  logic [2:0]  exp_digit;
  logic [15:0] chain_q;                 // 595 chain contents
  logic [31:0] rng_state;
  wire         flags_ok;
  int          errors;
  int          failed_tests;
  int          test_errors_start;

  tb_clock #(.PERIOD_NS(8.0)) u_clock (.sys_clk(sys_clk));

  segdisp_top uut (
    .sys_clk, .sys_rst_n, .host_data, .host_stb,
    .flag_a, .flag_b, .flag_c, .flag_d,
    .led, .cy_ifclk, .segled_clk, .segled_dat, .segled_str, .cmd_error
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Active-low hex glyphs, dp dark
  function automatic logic [7:0] hex_glyph(input logic [3:0] nib);
    logic [7:0] table_q [16];
    table_q = '{8'hC0, 8'hF9, 8'hA4, 8'hB0, 8'h99, 8'h92, 8'h82, 8'hF8,
                8'h80, 8'h90, 8'h88, 8'h83, 8'hC6, 8'hA1, 8'h86, 8'h8E};
    return table_q[nib];
  endfunction

  function automatic logic [7:0] expected_seg(input logic [31:0] bytes,
                                              input logic [3:0] blank,
                                              input logic [2:0] digit);
    logic [1:0] slot;
    logic [7:0] value;
    slot  = digit[2:1];
    value = bytes[slot*8 +: 8];
    if (blank[slot]) return 8'hFF;
    return digit[0] ? hex_glyph(value[3:0]) : hex_glyph(value[7:4]);
  endfunction

  assign flags_ok = !flag_a && flag_b && !flag_c && flag_d;

  always @(posedge segled_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) chain_q <= '0;
    else chain_q <= {chain_q[14:0], segled_dat};   // MSB arrives first
  end

  always @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      exp_digit   <= '0;
      frame_bytes <= '0;
      frame_blank <= '0;
    end else if (segled_str) begin
      exp_digit   <= exp_digit + 1'b1;  // Wraps after digit 7
      frame_bytes <= sb_bytes;
      frame_blank <= sb_blank;
    end
  end

  a_sel: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
    segled_str |-> $onehot(chain_q[7:0]) && chain_q[7:0] == (8'd1 << exp_digit))
    else begin
      errors++;
      $display("Error: t=%0t chain_q[7:0] expected %h got %h", $time,
               8'd1 << $sampled(exp_digit), $sampled(chain_q[7:0]));
    end

  a_seg: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
    segled_str |-> chain_q[15:8] == expected_seg(frame_bytes, frame_blank, exp_digit))
    else begin
      errors++;
      $display("Error: t=%0t chain_q[15:8] expected %h got %h", $time,
               expected_seg($sampled(frame_bytes), $sampled(frame_blank),
                            $sampled(exp_digit)), $sampled(chain_q[15:8]));
    end

  a_led: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
    led == $past(flags_ok, 3))
    else begin
      errors++;
      $display("Error: t=%0t led expected %b got %b", $time,
               $past(flags_ok, 3), $sampled(led));
    end

  a_ifclk: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
    $past(sys_rst_n) |-> cy_ifclk != $past(cy_ifclk))
    else begin
      errors++;
      $display("Error: t=%0t cy_ifclk expected %b got %b", $time,
               !$past(cy_ifclk), $sampled(cy_ifclk));
    end

  task automatic wait_frames(input int n);
    repeat (n) begin
      do @(posedge sys_clk); while (!segled_str);
    end
  endtask

  // Command right after a latch strobe so the running frame keeps old data
  task automatic send_pair(input logic [7:0] cmd, input logic [7:0] data);
    wait_frames(1);
    host_data <= cmd;
    host_stb  <= 1'b1;
    @(posedge sys_clk);
    host_data <= data;
    @(posedge sys_clk);
    host_stb  <= 1'b0;
  endtask

  task automatic check_cmd_error(input logic expected);
    @(posedge sys_clk);
    assert (cmd_error == expected)
      else begin
        errors++;
        $display("Error: t=%0t cmd_error expected %b got %b", $time, expected, cmd_error);
      end
  endtask

  task automatic finish_test(input string name);
    if (errors == test_errors_start) begin
      $display("Test %s: ok", name);
    end else begin
      failed_tests++;
      $display("Test %s: %0d errors", name, errors - test_errors_start);
    end
    test_errors_start = errors;
  endtask

  task automatic write_random(input logic [1:0] slot);
    rng_state = xorshift32(rng_state);
    send_pair({`CMD_WRITE, 2'b00, slot}, rng_state[7:0]);
    sb_bytes[slot*8 +: 8] = rng_state[7:0];
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge sys_clk);
    $display("Watchdog expired before all tests finished");
    $display("Simulation failed");
    $finish;
  end

  initial begin
    sys_rst_n = 1'b0;
    host_data = '0;
    host_stb  = 1'b0;
    {flag_a, flag_b, flag_c, flag_d} = 4'b0000;
    sb_bytes  = '0;
    sb_blank  = '0;
    rng_state = 32'd42607;
    errors = 0;
    failed_tests = 0;
    test_errors_start = 0;
    repeat (RESET_CYCLES) @(posedge sys_clk);
    sys_rst_n <= 1'b1;

    wait_frames(9);                     // Every digit shows 0
    check_cmd_error(1'b0);
    finish_test("reset_scan");

    repeat (2) begin
      for (int k = 0; k < `SLOT_COUNT; k++) write_random(k[1:0]);
    end
    wait_frames(9);
    check_cmd_error(1'b0);
    finish_test("random_write");

    send_pair({`CMD_BLANK, 4'h2}, 8'h01);
    sb_blank[2] = 1'b1;
    wait_frames(9);
    send_pair({`CMD_BLANK, 4'h2}, 8'hFE);   // Bit 0 clear
    sb_blank[2] = 1'b0;
    wait_frames(9);
    finish_test("blank");

    send_pair(8'h35, 8'hAA);            // Class 3
    check_cmd_error(1'b1);
    send_pair({`CMD_WRITE, 4'h6}, 8'h55);
    send_pair({`CMD_BLANK, 4'h7}, 8'h01);
    write_random(2'd1);                 // Pairs must stay aligned
    wait_frames(9);
    check_cmd_error(1'b1);
    finish_test("illegal_cmd");

    for (int p = 0; p < 16; p++) begin
      @(posedge sys_clk);
      {flag_d, flag_c, flag_b, flag_a} <= p[3:0];
      repeat (5) @(posedge sys_clk);
    end
    repeat (4) @(posedge sys_clk);
    finish_test("fx2_flags");

    $display("Tests run %0d, failed %0d, errors %0d", NUM_TESTS, failed_tests, errors);
    if (errors == 0 && failed_tests == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* segdisp.f */
+incdir+hw
hw/segdisp_pkg.sv
hw/cmd_decoder.sv
hw/digit_slot.sv
hw/hc595_scanner.sv
hw/fx2_link_status.sv
hw/segdisp_top.sv
sim/tb_clock.sv
sim/segdisp_tb.sv
